/* aes_key_schedule.f */
+incdir+.
aes_ks_pkg.sv
aes_sub_word.sv
aes_key_loader.sv
aes_expand_stage.sv
aes_round_key_drain.sv
aes_key_schedule.sv
aes_key_schedule_properties.sv
aes_key_schedule_tb.sv

/* run.sh */
#!/bin/sh
# build and run the AES-256 key schedule testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f aes_key_schedule.f \
    --top-module aes_key_schedule_tb -o aes_key_schedule_tb &&
./obj_dir/aes_key_schedule_tb +verilator+error+limit+100 ||
{ echo "simulation run failed"; exit 1; }

/* aes_key_schedule_tb.sv */
`default_nettype none

`include "aes_ks_cfg.svh"

module aes_key_schedule_tb;
    import aes_ks_pkg::*;

    localparam int num_random = 24;
    localparam int wait_limit = 2000;

    logic        clk = 1'b0;
    logic        rst;
    logic        key_valid;
    cipher_key_t key;
    logic        key_credit;
    logic        rk_valid;
    rk_item_t    rk;
    logic        rk_credit;

    cipher_key_t sent_keys[$];
    int          keys_sent;
    int          credits_seen;
    int          keys_done;
    int          beats_seen;
    int          next_idx;
    round_key_t  got_rk [`AES_KS_NUM_RK];
    cipher_key_t vector_key;
    round_key_t  vector_rk14;

    aes_key_schedule dut0 (
        .clk       (clk),
        .rst       (rst),
        .key_valid (key_valid),
        .key       (key),
        .key_credit(key_credit),
        .rk_valid  (rk_valid),
        .rk        (rk),
        .rk_credit (rk_credit)
    );

    bind aes_key_schedule aes_key_schedule_properties u_props (
        .clk       (clk),
        .rst       (rst),
        .key_valid (key_valid),
        .key_credit(key_credit),
        .rk_valid  (rk_valid),
        .rk_credit (rk_credit)
    );

    always #5 clk = ~clk;

    // ------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("Simulation FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic report_error(input string msg);
        abort_run($sformatf("CHECK FAILED at time %0t: %s", $time, msg));
    endtask

    task automatic timed_out(input string what);
        abort_run($sformatf("timeout at time %0t: %s", $time, what));
    endtask

    // FIPS-197 writes byte 0 first while the DUT keeps byte 0 in the low bits
    function automatic cipher_key_t key_from_fips(input logic [255:0] hex);
        cipher_key_t k;
        for (int i = 0; i < 32; i++) begin
            k[8*i +: 8] = hex[255-8*i -: 8];
        end
        return k;
    endfunction

    function automatic round_key_t rk_from_fips(input logic [127:0] hex);
        round_key_t k;
        for (int i = 0; i < 16; i++) begin
            k[8*i +: 8] = hex[127-8*i -: 8];
        end
        return k;
    endfunction

    function automatic cipher_key_t random_key();
        cipher_key_t k;
        for (int i = 0; i < 8; i++) begin
            k[32*i +: 32] = $urandom;
        end
        return k;
    endfunction

    // word j of key i is word j of key i-2 xor word j-1 of key i
    function automatic bit follows_recurrence(input round_key_t cur, input round_key_t back2);
        bit ok;
        ok = 1'b1;
        for (int j = 1; j < 4; j++) begin
            if (cur[32*j +: 32] != (back2[32*j +: 32] ^ cur[32*(j-1) +: 32])) begin
                ok = 1'b0;
            end
        end
        return ok;
    endfunction

    task automatic send_key(input cipher_key_t k);
        int waited;
        waited = 0;
        while (`AES_KS_SCHED_SLOTS + credits_seen - keys_sent <= 0) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > wait_limit) begin
                timed_out("key_credit never gave the source a slot back");
            end
        end
        key_valid = 1'b1;
        key       = k;
        sent_keys.push_back(k);
        keys_sent++;
        @(posedge clk);
        #1;
        key_valid = 1'b0;
    endtask

    task automatic wait_all_done();
        int waited;
        waited = 0;
        while (keys_done < keys_sent) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > wait_limit) begin
                timed_out("the round keys of an accepted key never all came out");
            end
        end
    endtask

    task automatic check_beat();
        int          idx;
        cipher_key_t src;
        idx = int'(rk.idx);
        assert (keys_done < sent_keys.size())
            else report_error("round key beat with no accepted key outstanding");
        src = sent_keys[keys_done];
        assert (rk.tag == key_tag_t'(keys_done))
            else report_error($sformatf("tag %0d, expected %0d", rk.tag, keys_done % 16));
        assert (idx == next_idx)
            else report_error($sformatf("index %0d, expected %0d", idx, next_idx));
        got_rk[idx] = rk.key;
        if (idx == 0) begin
            assert (rk.key == src[127:0])
                else report_error("round key 0 is not the low half of the cipher key");
        end else if (idx == 1) begin
            assert (rk.key == src[255:128])
                else report_error("round key 1 is not the high half of the cipher key");
        end else begin
            assert (follows_recurrence(rk.key, got_rk[idx-2]))
                else report_error($sformatf("round key %0d breaks the word recurrence", idx));
        end
        if (idx == `AES_KS_NUM_RK - 1 && src == vector_key) begin
            assert (rk.key == vector_rk14)
                else report_error($sformatf("known vector round key 14 is %h", rk.key));
        end
        beats_seen++;
        if (idx == `AES_KS_NUM_RK - 1) begin
            keys_done++;
            next_idx = 0;
        end else begin
            next_idx++;
        end
    endtask

    // ------------------------------------------------------------------
    // processes
    // ------------------------------------------------------------------

    // outputs are sampled at the falling edge away from the drive point
    always @(negedge clk) begin
        if (rst) begin
            credits_seen = 0;
            keys_done    = 0;
            beats_seen   = 0;
            next_idx     = 0;
        end else begin
            assert (dut0.u_props.fail_count == 0)
                else report_error("a handshake property on the DUT ports failed");
            if (key_credit) begin
                credits_seen++;
            end
            if (rk_valid) begin
                check_beat();
            end
        end
    end

    initial begin : sink
        int hold;
        int credits_back;
        hold         = 0;
        credits_back = 0;
        rk_credit    = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            rk_credit = 1'b0;
            if (hold > 0) begin
                hold--;
            end else if ($urandom % 32 == 0) begin
                // withhold credits for a while so the stream stalls
                hold = 8 + int'($urandom % 16);
            end else if (beats_seen > credits_back && $urandom % 4 != 0) begin
                rk_credit = 1'b1;
                credits_back++;
            end
        end
    end

    initial begin : main
        int gap;
        void'($urandom(32'h236a_2fd6));
        rst         = 1'b1;
        key_valid   = 1'b0;
        key         = '0;
        keys_sent   = 0;
        vector_key  = key_from_fips({128'h603deb10_15ca71be_2b73aef0_857d7781,
                                     128'h1f352c07_3b6108d7_2d9810a3_0914dff4});
        vector_rk14 = rk_from_fips(128'hfe4890d1_e6188d0b_046df344_706c631e);
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        send_key(vector_key);
        for (int n = 0; n < num_random; n++) begin
            gap = int'($urandom % 4);
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
            send_key(random_key());
        end
        wait_all_done();
        if (dut0.u_props.fail_count != 0) begin
            report_error("a handshake property on the DUT ports failed");
        end else begin
            $display("Simulation PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* aes_key_schedule_properties.sv */
`default_nettype none

`include "aes_ks_cfg.svh"

module aes_key_schedule_properties (
    input logic clk,
    input logic rst,
    input logic key_valid,
    input logic key_credit,
    input logic rk_valid,
    input logic rk_credit
);

    // running totals over the cycles before the current one
    int keys_in;
    int keys_back;
    int beats_out;
    int credits_in;
    int idle_run;
    int fail_count = 0;

    int credits_held;
    int beats_pending;

    assign credits_held  = `AES_KS_RK_CREDITS + credits_in - beats_out;
    assign beats_pending = `AES_KS_NUM_RK * keys_in - beats_out;

    always_ff @(posedge clk) begin
        if (rst) begin
            keys_in    <= 0;
            keys_back  <= 0;
            beats_out  <= 0;
            credits_in <= 0;
            idle_run   <= 0;
        end else begin
            if (key_valid) begin
                keys_in <= keys_in + 1;
            end
            if (key_credit) begin
                keys_back <= keys_back + 1;
            end
            if (rk_valid) begin
                beats_out <= beats_out + 1;
            end
            if (rk_credit) begin
                credits_in <= credits_in + 1;
            end
            // beats owed and a credit in hand, yet the stream is quiet
            if (!rk_valid && beats_pending > 0 && credits_held > 0) begin
                idle_run <= idle_run + 1;
            end else begin
                idle_run <= 0;
            end
        end
    end

    reset_quiet: assert property (@(posedge clk) rst |=> (!rk_valid && !key_credit))
        else begin
            $error("rk_valid or key_credit high in the cycle after reset");
            fail_count++;
        end

    beats_within_credit: assert property (@(posedge clk) disable iff (rst)
        beats_out + (rk_valid ? 1 : 0) <= credits_in + `AES_KS_RK_CREDITS)
        else begin
            $error("rk_valid used more credits than the sink gave");
            fail_count++;
        end

    credit_after_key: assert property (@(posedge clk) disable iff (rst)
        keys_back + (key_credit ? 1 : 0) <= keys_in)
        else begin
            $error("more key_credit pulses than accepted keys");
            fail_count++;
        end

    source_has_credit: assert property (@(posedge clk) disable iff (rst)
        key_valid |-> (keys_in - keys_back < `AES_KS_SCHED_SLOTS))
        else begin
            $error("key_valid raised without an input credit");
            fail_count++;
        end

    // pipeline latency is 9 cycles, so a stall longer than that never ends
    stream_resumes: assert property (@(posedge clk) disable iff (rst) idle_run < 12)
        else begin
            $error("round key stream did not resume with credit available");
            fail_count++;
        end

endmodule

`default_nettype wire

/* aes_key_schedule.sv */
`default_nettype none

`include "aes_ks_cfg.svh"

module aes_key_schedule (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    key_valid,
    input  aes_ks_pkg::cipher_key_t key,
    output logic                    key_credit,
    output logic                    rk_valid,
    output aes_ks_pkg::rk_item_t    rk,
    input  logic                    rk_credit
);
    import aes_ks_pkg::*;

    // sched_pipe[0] from the loader, sched_pipe[n] from stage n
    sched_t sched_pipe [`AES_KS_NUM_STAGES+1];
    logic   slot_free;

    aes_key_loader u_loader (
        .clk       (clk),
        .rst       (rst),
        .key_valid (key_valid),
        .key       (key),
        .slot_free (slot_free),
        .key_credit(key_credit),
        .sched     (sched_pipe[0])
    );

    // ------------------------------------------------------------------
    // expansion pipeline
    // ------------------------------------------------------------------

    for (genvar s = 0; s < `AES_KS_NUM_STAGES; s++) begin : g_stage
        aes_expand_stage #(
            .stage_num(s + 1)
        ) u_stage (
            .clk      (clk),
            .rst      (rst),
            .sched_in (sched_pipe[s]),
            .sched_out(sched_pipe[s+1])
        );
    end

    aes_round_key_drain u_drain (
        .clk      (clk),
        .rst      (rst),
        .sched    (sched_pipe[`AES_KS_NUM_STAGES]),
        .rk_valid (rk_valid),
        .rk       (rk),
        .rk_credit(rk_credit),
        .slot_free(slot_free)
    );

endmodule

`default_nettype wire

/* aes_round_key_drain.sv */
`default_nettype none

`include "aes_ks_cfg.svh"

module aes_round_key_drain (
    input  logic                 clk,
    input  logic                 rst,
    input  aes_ks_pkg::sched_t   sched,
    output logic                 rk_valid,
    output aes_ks_pkg::rk_item_t rk,
    input  logic                 rk_credit,
    output logic                 slot_free
);
    import aes_ks_pkg::*;

    localparam int slots    = `AES_KS_SCHED_SLOTS;
    localparam int ptr_w    = (slots > 1) ? $clog2(slots) : 1;
    localparam int credit_w = $clog2(`AES_KS_RK_CREDITS + 1);

    typedef logic [ptr_w-1:0]    slot_ptr_t;
    typedef logic [credit_w-1:0] credit_t;

    function automatic slot_ptr_t ring_next(input slot_ptr_t p);
        if (p == slot_ptr_t'(slots - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    // ------------------------------------------------------------------
    // schedule ring
    // ------------------------------------------------------------------

    // round key 15 of the last stage is never sent, so it is not kept
    round_key_t [`AES_KS_NUM_RK-1:0] key_mem [slots];
    key_tag_t                        tag_mem [slots];

    logic [slots-1:0] slot_full;
    slot_ptr_t        wr_ptr;
    slot_ptr_t        rd_ptr;
    rk_index_t        rk_idx;
    credit_t          credits;
    logic             last_beat;

    always_ff @(posedge clk) begin
        if (sched.valid) begin
            key_mem[wr_ptr] <= sched.rk[`AES_KS_NUM_RK-1:0];
            tag_mem[wr_ptr] <= sched.tag;
        end
    end

    // ------------------------------------------------------------------
    // stream out
    // ------------------------------------------------------------------

    assign rk_valid  = slot_full[rd_ptr] && (credits != '0);
    assign last_beat = rk_valid && (rk_idx == rk_index_t'(`AES_KS_NUM_RK - 1));
    assign slot_free = last_beat;

    assign rk = '{
        tag: tag_mem[rd_ptr],
        idx: rk_idx,
        key: key_mem[rd_ptr][rk_idx]
    };

    // input credits keep the write side from landing on a full slot
    always_ff @(posedge clk) begin
        if (rst) begin
            slot_full <= '0;
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            rk_idx    <= '0;
        end else begin
            if (last_beat) begin
                slot_full[rd_ptr] <= 1'b0;
                rd_ptr            <= ring_next(rd_ptr);
                rk_idx            <= '0;
            end else if (rk_valid) begin
                rk_idx <= rk_idx + 1'b1;
            end
            if (sched.valid) begin
                slot_full[wr_ptr] <= 1'b1;
                wr_ptr            <= ring_next(wr_ptr);
            end
        end
    end

    // one credit per beat, one back per rk_credit pulse
    always_ff @(posedge clk) begin
        if (rst) begin
            credits <= credit_t'(`AES_KS_RK_CREDITS);
        end else begin
            case ({rk_valid, rk_credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

endmodule

`default_nettype wire

/* aes_expand_stage.sv */
`default_nettype none

module aes_expand_stage #(
    parameter int stage_num = 1
) (
    input  logic               clk,
    input  logic               rst,
    input  aes_ks_pkg::sched_t sched_in,
    output aes_ks_pkg::sched_t sched_out
);
    import aes_ks_pkg::*;

    localparam int         even_in  = 2 * stage_num - 2;
    localparam int         odd_in   = 2 * stage_num - 1;
    localparam int         even_out = 2 * stage_num;
    localparam int         odd_out  = 2 * stage_num + 1;
    localparam logic [7:0] rcon     = rcon_for_round(stage_num);

    // w[i] = prev[i] ^ w[i-1], word 0 takes the transformed head word
    function automatic round_key_t chain_words(input round_key_t prev, input word_t head);
        round_key_t res;
        res[31:0] = prev[31:0] ^ head;
        for (int i = 1; i < 4; i++) begin
            res[32*i +: 32] = prev[32*i +: 32] ^ res[32*(i-1) +: 32];
        end
        return res;
    endfunction

    word_t      last_odd;
    word_t      rot_word;
    word_t      sub_rot;
    word_t      sub_even;
    round_key_t even_key;
    round_key_t odd_key;
    sched_t     sched_nxt;

    // byte 0 sits in the low bits, so RotWord is a right rotate
    assign last_odd = sched_in.rk[odd_in][127:96];
    assign rot_word = {last_odd[7:0], last_odd[31:8]};

    aes_sub_word u_sub_rot (
        .word(rot_word),
        .sub (sub_rot)
    );

    assign even_key = chain_words(sched_in.rk[even_in], sub_rot ^ {24'h0, rcon});

    // odd key: SubWord only, no rotation and no Rcon
    aes_sub_word u_sub_even (
        .word(even_key[127:96]),
        .sub (sub_even)
    );

    assign odd_key = chain_words(sched_in.rk[odd_in], sub_even);

    always_comb begin
        sched_nxt              = sched_in;
        sched_nxt.rk[even_out] = even_key;
        sched_nxt.rk[odd_out]  = odd_key;
    end

    always_ff @(posedge clk) begin
        sched_out <= sched_nxt;
        if (rst) begin
            sched_out.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* aes_key_loader.sv */
`default_nettype none

module aes_key_loader (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    key_valid,
    input  aes_ks_pkg::cipher_key_t key,
    input  logic                    slot_free,
    output logic                    key_credit,
    output aes_ks_pkg::sched_t      sched
);
    import aes_ks_pkg::*;

    key_tag_t next_tag;

    // tag counter wraps, the drain keeps acceptance order anyway
    always_ff @(posedge clk) begin
        if (rst) begin
            next_tag   <= '0;
            key_credit <= 1'b0;
        end else begin
            key_credit <= slot_free;
            if (key_valid) begin
                next_tag <= next_tag + 1'b1;
            end
        end
    end

    // schedule record for stage 1
    always_ff @(posedge clk) begin
        sched.valid <= key_valid;
        if (key_valid) begin
            sched.tag      <= next_tag;
            sched.rk[0]    <= key[127:0];
            sched.rk[1]    <= key[255:128];
            // upper entries are filled in by the stages
            sched.rk[15:2] <= '0;
        end
        if (rst) begin
            sched.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* aes_sub_word.sv */
`default_nettype none

module aes_sub_word (
    input  aes_ks_pkg::word_t word,
    output aes_ks_pkg::word_t sub
);

    // ------------------------------------------------------------------
    // forward S-box
    // ------------------------------------------------------------------

    // one 16-byte row per high nibble, column 0 in the top byte
    function automatic logic [7:0] sbox(input logic [7:0] b);
        logic [127:0] row;
        case (b[7:4])
            4'h0:    row = 128'h637c777b_f26b6fc5_3001672b_fed7ab76;
            4'h1:    row = 128'hca82c97d_fa5947f0_add4a2af_9ca472c0;
            4'h2:    row = 128'hb7fd9326_363ff7cc_34a5e5f1_71d83115;
            4'h3:    row = 128'h04c723c3_1896059a_071280e2_eb27b275;
            4'h4:    row = 128'h09832c1a_1b6e5aa0_523bd6b3_29e32f84;
            4'h5:    row = 128'h53d100ed_20fcb15b_6acbbe39_4a4c58cf;
            4'h6:    row = 128'hd0efaafb_434d3385_45f9027f_503c9fa8;
            4'h7:    row = 128'h51a3408f_929d38f5_bcb6da21_10fff3d2;
            4'h8:    row = 128'hcd0c13ec_5f974417_c4a77e3d_645d1973;
            4'h9:    row = 128'h60814fdc_222a9088_46eeb814_de5e0bdb;
            4'ha:    row = 128'he0323a0a_4906245c_c2d3ac62_9195e479;
            4'hb:    row = 128'he7c8376d_8dd54ea9_6c56f4ea_657aae08;
            4'hc:    row = 128'hba78252e_1ca6b4c6_e8dd741f_4bbd8b8a;
            4'hd:    row = 128'h703eb566_4803f60e_613557b9_86c11d9e;
            4'he:    row = 128'he1f89811_69d98e94_9b1e87e9_ce5528df;
            default: row = 128'h8ca1890d_bfe64268_41992d0f_b054bb16;
        endcase
        return row[8*(15-b[3:0]) +: 8];
    endfunction

    // ------------------------------------------------------------------
    // byte lanes
    // ------------------------------------------------------------------

    // substitution is byte-wise, so lane order does not matter here
    for (genvar i = 0; i < 4; i++) begin : g_byte
        assign sub[8*i +: 8] = sbox(word[8*i +: 8]);
    end

endmodule

`default_nettype wire

/* aes_ks_pkg.sv */
`default_nettype none

`include "aes_ks_cfg.svh"

package aes_ks_pkg;

    typedef logic [31:0]  word_t;
    typedef logic [127:0] round_key_t;
    typedef logic [255:0] cipher_key_t;
    typedef logic [3:0]   rk_index_t;
    typedef logic [3:0]   key_tag_t;

    // partial schedule moving down the pipeline
    // rk[0] and rk[1] hold the cipher key, stage n fills rk[2n] and rk[2n+1]
    typedef struct packed {
        logic                                  valid;
        key_tag_t                              tag;
        round_key_t [2*`AES_KS_NUM_STAGES+1:0] rk;
    } sched_t;

    // one beat of the round key stream
    typedef struct packed {
        key_tag_t   tag;
        rk_index_t  idx;
        round_key_t key;
    } rk_item_t;

    // Rcon byte used by expansion stage 1..7
    function automatic logic [7:0] rcon_for_round(input int unsigned stage);
        logic [7:0] rcon;
        case (stage)
            1:       rcon = 8'h01;
            2:       rcon = 8'h02;
            3:       rcon = 8'h04;
            4:       rcon = 8'h08;
            5:       rcon = 8'h10;
            6:       rcon = 8'h20;
            7:       rcon = 8'h40;
            default: rcon = 8'h00;
        endcase
        return rcon;
    endfunction

endpackage

`default_nettype wire

/* aes_ks_cfg.svh */
`ifndef AES_KS_CFG_SVH
`define AES_KS_CFG_SVH

// schedules accepted but not yet fully streamed out
// also the input credits the source holds after reset
`define AES_KS_SCHED_SLOTS 2

// output credits held by the drain after reset
`define AES_KS_RK_CREDITS 4

// each expansion stage adds an even and an odd round key
`define AES_KS_NUM_STAGES 7

// round keys streamed per cipher key
`define AES_KS_NUM_RK 15

`endif
